// ==== rtl/vec_types_pkg.sv ====
/*
  Element, vector-length and instruction-field types for the vector decode stage.
  vl never exceeds VLMAX, because lmul grouping is not supported.
  vtype sew codes above SEW32 are treated as SEW32.
*/
package vec_types_pkg;

  localparam int VLMAX    = 16;
  localparam int OFFSET_W = 5;
  localparam int XLEN     = 32;

  localparam logic [6:0] OPCODE_OPV = 7'b1010111;

  // funct6 encodings of the supported ops
  localparam logic [5:0] F6_VADD        = 6'b000000;
  localparam logic [5:0] F6_VSUB        = 6'b000010;
  localparam logic [5:0] F6_VRGATHER    = 6'b001100;
  localparam logic [5:0] F6_VSLIDE1UP   = 6'b001110;
  localparam logic [5:0] F6_VSLIDE1DOWN = 6'b001111;
  localparam logic [5:0] F6_VNSRL       = 6'b101100;
  localparam logic [5:0] F6_VWADDU      = 6'b110000;

  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [XLEN-1:0]     xword_t;
  typedef logic [4:0]          vreg_t;

  typedef enum logic [1:0] {SEW8 = 2'd0, SEW16 = 2'd1, SEW32 = 2'd2} sew_t;

  typedef enum logic [3:0] {
    VALU_NOP, VALU_ADD, VALU_SUB, VALU_WADDU, VALU_NSRL,
    VALU_SLIDE1UP, VALU_SLIDE1DOWN, VALU_RGATHER
  } valu_op_t;

  // funct3 forms of the OP-V major opcode
  typedef enum logic [2:0] {
    OPIVV = 3'b000, OPMVV = 3'b010, OPIVI = 3'b011, OPIVX = 3'b100, OPMVX = 3'b110
  } opv_fmt_t;

  typedef enum logic [1:0] {VS2_SRC_NORMAL, VS2_SRC_IDX_PLUS_1, VS2_SRC_VS1} vs2_src_t;
  typedef enum logic {VD_SRC_NORMAL, VD_SRC_IDX_PLUS_1} vd_src_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    vreg_t      vs2;
    vreg_t      vs1;
    logic [2:0] funct3;
    vreg_t      vd;
    logic [6:0] opcode;
  } opv_instr_t;

  typedef struct packed {
    offset_t    vl;
    logic [7:0] vtype;
  } csr_state_t;

  function automatic sew_t vtype_sew(input logic [7:0] vtype);
    case (vtype[5:3])
      3'd0:    return SEW8;
      3'd1:    return SEW16;
      default: return SEW32;
    endcase
  endfunction

endpackage

// ==== rtl/vdecode_pkg.sv ====
/*
  Structs carried between the decode modules and on the stage ports.
  Register file request and response cover two lanes per cycle.
*/
package vdecode_pkg;

  import vec_types_pkg::*;

  // decoded instruction, held for the whole walk
  typedef struct packed {
    valu_op_t aluop;
    vreg_t    vs1;
    vreg_t    vs2;
    vreg_t    vd;
    logic     vm;
    vs2_src_t vs2_src;
    vd_src_t  vd_src;
    logic     widen;
    logic     narrow;
    xword_t   scalar;
  } vctrl_t;

  typedef struct packed {
    vreg_t   vs1;
    vreg_t   vs2;
    vreg_t   vd;
    offset_t vs1_offset;
    offset_t vs2_offset;
    offset_t vd_offset;
    sew_t    sew;
    sew_t    vs2_sew;
  } rf_req_t;

  // index 0 is lane 0
  typedef struct packed {
    xword_t [1:0] vs1_data;
    xword_t [1:0] vs2_data;
    xword_t [1:0] vs3_data;
    logic   [1:0] v0_mask;
  } rf_rsp_t;

  typedef struct packed {
    logic     valid;
    valu_op_t aluop;
    vreg_t    vd;
    sew_t     eew;
    sew_t     sew;
    offset_t  woffset0;
    offset_t  woffset1;
    logic [1:0] wen;
    xword_t   vs1_lane0;
    xword_t   vs1_lane1;
    xword_t   vs2_lane0;
    xword_t   vs2_lane1;
    xword_t   vs3_lane0;
    xword_t   vs3_lane1;
    xword_t   scalar;
    offset_t  vs2_offset0;
    offset_t  vs2_offset1;
  } de_uop_t;

endpackage

// ==== rtl/vctrl_decode.sv ====
/*
  Captures instr, xs1 and csr on accept and decodes the held instruction.
  vsub has no immediate form and vrgather is decoded for .vv only.
  Anything else, including a non OP-V opcode, decodes to VALU_NOP.
*/
module vctrl_decode (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      accept,
  input  vec_types_pkg::xword_t     instr,
  input  vec_types_pkg::xword_t     xs1,
  input  vec_types_pkg::csr_state_t csr,
  output vdecode_pkg::vctrl_t       ctrl,
  output vec_types_pkg::csr_state_t csr_q
);
  import vec_types_pkg::*;
  import vdecode_pkg::*;

  opv_instr_t instr_q;
  xword_t     xs1_q;
  opv_fmt_t   fmt;
  valu_op_t   aluop;
  logic       scalar_x;
  logic       imm_signed;
  xword_t     imm_ext;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      instr_q <= '0;
      xs1_q   <= '0;
      csr_q   <= '0;
    end else if (accept) begin
      instr_q <= opv_instr_t'(instr);
      xs1_q   <= xs1;
      csr_q   <= csr;
    end
  end

  assign fmt = opv_fmt_t'(instr_q.funct3);

  always_comb begin
    aluop = VALU_NOP;
    if (instr_q.opcode == OPCODE_OPV) begin
      case (fmt)
        OPIVV, OPIVX, OPIVI: begin
          case (instr_q.funct6)
            F6_VADD:     aluop = VALU_ADD;
            F6_VSUB:     aluop = (fmt != OPIVI) ? VALU_SUB : VALU_NOP;
            F6_VNSRL:    aluop = VALU_NSRL;
            F6_VRGATHER: aluop = (fmt == OPIVV) ? VALU_RGATHER : VALU_NOP;
            default:     aluop = VALU_NOP;
          endcase
        end
        OPMVV, OPMVX: begin
          case (instr_q.funct6)
            F6_VWADDU:      aluop = VALU_WADDU;
            F6_VSLIDE1UP:   aluop = (fmt == OPMVX) ? VALU_SLIDE1UP : VALU_NOP;
            F6_VSLIDE1DOWN: aluop = (fmt == OPMVX) ? VALU_SLIDE1DOWN : VALU_NOP;
            default:        aluop = VALU_NOP;
          endcase
        end
        default: aluop = VALU_NOP;
      endcase
    end
  end

  // imm5 sits in the vs1 field
  assign scalar_x   = (fmt == OPIVX) || (fmt == OPMVX);
  assign imm_signed = (aluop == VALU_ADD) || (aluop == VALU_SUB);
  assign imm_ext    = imm_signed ? {{27{instr_q.vs1[4]}}, instr_q.vs1}
                                 : {27'd0, instr_q.vs1};

  always_comb begin
    ctrl.aluop   = aluop;
    ctrl.vs1     = instr_q.vs1;
    ctrl.vs2     = instr_q.vs2;
    ctrl.vd      = instr_q.vd;
    ctrl.vm      = instr_q.vm;
    ctrl.vs2_src = VS2_SRC_NORMAL;
    ctrl.vd_src  = VD_SRC_NORMAL;
    ctrl.widen   = (aluop == VALU_WADDU);
    ctrl.narrow  = (aluop == VALU_NSRL);
    ctrl.scalar  = scalar_x ? xs1_q : imm_ext;
    case (aluop)
      VALU_SLIDE1DOWN: ctrl.vs2_src = VS2_SRC_IDX_PLUS_1;
      VALU_RGATHER:    ctrl.vs2_src = VS2_SRC_VS1;
      VALU_SLIDE1UP:   ctrl.vd_src  = VD_SRC_IDX_PLUS_1;
      default:         ctrl.vs2_src = VS2_SRC_NORMAL;
    endcase
  end

endmodule

// ==== rtl/element_counter.sv ====
/*
  Acceptance, busy flag and the two-element offset walk.
  A walk of vl elements takes ceil(vl/2) cycles, and one cycle when vl is 0.
  Flush abandons the walk and wins over stall.
*/
module element_counter (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   instr_valid,
  input  logic                   stall,
  input  logic                   flush,
  input  vec_types_pkg::offset_t vl,
  output logic                   accept,
  output logic                   busy,
  output vec_types_pkg::offset_t offset,
  output logic                   last
);
  import vec_types_pkg::*;

  // one extra bit so the compare against vl cannot wrap
  logic [OFFSET_W:0] pair_end;

  assign accept   = instr_valid && !busy && !stall && !flush;
  assign pair_end = {1'b0, offset} + (OFFSET_W + 1)'(2);
  assign last     = pair_end >= {1'b0, vl};

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      busy   <= 1'b0;
      offset <= '0;
    end else if (flush) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy   <= 1'b1;
      offset <= '0;
    end else if (busy && !stall) begin
      offset <= pair_end[OFFSET_W-1:0];
      // the pair being consumed now is the final one
      if (last) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/operand_offset_gen.sv ====
/*
  Per-lane source and destination offsets and the register file read request.
  The request carries lane 0 offsets; the register file returns two lanes.
  rgather takes its vs2 offsets from the low bits of the vs1 data.
*/
module operand_offset_gen (
  input  vdecode_pkg::vctrl_t       ctrl,
  input  vec_types_pkg::csr_state_t csr,
  input  vec_types_pkg::offset_t    offset,
  input  vdecode_pkg::rf_rsp_t      rf_rsp,
  output vdecode_pkg::rf_req_t      rf_req,
  output vec_types_pkg::offset_t    vs2_offset0,
  output vec_types_pkg::offset_t    vs2_offset1,
  output vec_types_pkg::offset_t    woffset0,
  output vec_types_pkg::offset_t    woffset1
);
  import vec_types_pkg::*;
  import vdecode_pkg::*;

  sew_t    sew;
  sew_t    vs2_sew;
  offset_t offset_p1;
  offset_t offset_p2;

  assign offset_p1 = offset + offset_t'(1);
  assign offset_p2 = offset + offset_t'(2);
  assign sew       = vtype_sew(csr.vtype);

  always_comb begin
    case (ctrl.vs2_src)
      VS2_SRC_IDX_PLUS_1: begin
        vs2_offset0 = offset_p1;
        vs2_offset1 = offset_p2;
      end
      VS2_SRC_VS1: begin
        vs2_offset0 = rf_rsp.vs1_data[0][OFFSET_W-1:0];
        vs2_offset1 = rf_rsp.vs1_data[1][OFFSET_W-1:0];
      end
      default: begin
        vs2_offset0 = offset;
        vs2_offset1 = offset_p1;
      end
    endcase
  end

  // slide1up writes one element above the source
  assign woffset0 = (ctrl.vd_src == VD_SRC_IDX_PLUS_1) ? offset_p1 : offset;
  assign woffset1 = (ctrl.vd_src == VD_SRC_IDX_PLUS_1) ? offset_p2 : offset_p1;

  // narrowing reads vs2 at twice the element width
  always_comb begin
    vs2_sew = sew;
    if (ctrl.narrow) begin
      case (sew)
        SEW8:    vs2_sew = SEW16;
        default: vs2_sew = SEW32;
      endcase
    end
  end

  assign rf_req.vs1        = ctrl.vs1;
  assign rf_req.vs2        = ctrl.vs2;
  assign rf_req.vd         = ctrl.vd;
  assign rf_req.vs1_offset = offset;
  assign rf_req.vs2_offset = vs2_offset0;
  assign rf_req.vd_offset  = woffset0;
  assign rf_req.sew        = sew;
  assign rf_req.vs2_sew    = vs2_sew;

endmodule

// ==== rtl/de_pipe_reg.sv ====
/*
  Lane patching, write enables, eew and the decode-to-execute register.
  Stall holds the whole micro-op; flush zeroes it at the next edge.
  The slide1down scalar lands on the element whose source index is vl.
*/
module de_pipe_reg (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      stall,
  input  logic                      flush,
  input  logic                      busy,
  input  vdecode_pkg::vctrl_t       ctrl,
  input  vec_types_pkg::csr_state_t csr,
  input  vec_types_pkg::offset_t    offset,
  input  vec_types_pkg::offset_t    vs2_offset0,
  input  vec_types_pkg::offset_t    vs2_offset1,
  input  vec_types_pkg::offset_t    woffset0,
  input  vec_types_pkg::offset_t    woffset1,
  input  vdecode_pkg::rf_rsp_t      rf_rsp,
  output vdecode_pkg::de_uop_t      uop
);
  import vec_types_pkg::*;
  import vdecode_pkg::*;

  sew_t              sew;
  sew_t              eew;
  logic              advance;
  logic              slide_down;
  logic [OFFSET_W:0] vl_ext;
  logic [1:0]        scalar_hit;
  logic [1:0]        wen;
  xword_t            vs2_lane0;
  xword_t            vs2_lane1;

  function automatic xword_t patch_vs2(input xword_t data, input logic narrow,
                                       input sew_t s, input logic hit, input xword_t scalar);
    if (narrow && s == SEW32) begin
      return {16'd0, data[15:0]};
    end else if (narrow && s == SEW16) begin
      return {24'd0, data[7:0]};
    end else if (hit) begin
      return scalar;
    end
    return data;
  endfunction

  function automatic logic lane_wen(input valu_op_t op, input offset_t woff,
                                    input offset_t vl, input logic vm, input logic mask);
    return (op != VALU_NOP) && (woff < vl) && (vm || mask);
  endfunction

  assign sew     = vtype_sew(csr.vtype);
  assign advance = busy && !stall;

  always_comb begin
    eew = sew;
    if (ctrl.widen) begin
      eew = (sew == SEW8) ? SEW16 : SEW32;
    end else if (ctrl.narrow) begin
      eew = (sew == SEW32) ? SEW16 : SEW8;
    end
  end

  // lane i reads source element offset+i+1, so it carries the scalar when that index is vl
  assign slide_down    = (ctrl.aluop == VALU_SLIDE1DOWN);
  assign vl_ext        = {1'b0, csr.vl};
  assign scalar_hit[0] = slide_down && ({1'b0, offset} + 6'd1 == vl_ext);
  assign scalar_hit[1] = slide_down && ({1'b0, offset} + 6'd2 == vl_ext);

  assign vs2_lane0 = patch_vs2(rf_rsp.vs2_data[0], ctrl.narrow, sew, scalar_hit[0], ctrl.scalar);
  assign vs2_lane1 = patch_vs2(rf_rsp.vs2_data[1], ctrl.narrow, sew, scalar_hit[1], ctrl.scalar);

  assign wen[0] = lane_wen(ctrl.aluop, woffset0, csr.vl, ctrl.vm, rf_rsp.v0_mask[0]);
  assign wen[1] = lane_wen(ctrl.aluop, woffset1, csr.vl, ctrl.vm, rf_rsp.v0_mask[1]);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      uop <= '0;
    end else if (flush) begin
      uop <= '0;
    end else if (advance) begin
      uop.valid       <= 1'b1;
      uop.aluop       <= ctrl.aluop;
      uop.vd          <= ctrl.vd;
      uop.eew         <= eew;
      uop.sew         <= sew;
      uop.woffset0    <= woffset0;
      uop.woffset1    <= woffset1;
      uop.wen         <= wen;
      uop.vs1_lane0   <= rf_rsp.vs1_data[0];
      uop.vs1_lane1   <= rf_rsp.vs1_data[1];
      uop.vs2_lane0   <= vs2_lane0;
      uop.vs2_lane1   <= vs2_lane1;
      uop.vs3_lane0   <= rf_rsp.vs3_data[0];
      uop.vs3_lane1   <= rf_rsp.vs3_data[1];
      uop.scalar      <= ctrl.scalar;
      uop.vs2_offset0 <= vs2_offset0;
      uop.vs2_offset1 <= vs2_offset1;
    end else if (!stall) begin
      // bubble between instructions
      uop.valid <= 1'b0;
      uop.wen   <= '0;
    end
  end

endmodule

// ==== rtl/vdecode_stage.sv ====
/*
  Vector decode stage top level, two elements per cycle.
  The register file sits outside and answers rf_req in the same cycle.
*/
module vdecode_stage (
  input  logic                      CLK,
  input  logic                      nRST,
  input  vec_types_pkg::xword_t     instr,
  input  logic                      instr_valid,
  input  vec_types_pkg::xword_t     xs1,
  input  vec_types_pkg::csr_state_t csr,
  input  logic                      stall,
  input  logic                      flush,
  input  vdecode_pkg::rf_rsp_t      rf_rsp,
  output logic                      busy,
  output vdecode_pkg::rf_req_t      rf_req,
  output vdecode_pkg::de_uop_t      uop
);
  import vec_types_pkg::*;
  import vdecode_pkg::*;

  logic       accept;
  offset_t    offset;
  offset_t    vs2_offset0, vs2_offset1, woffset0, woffset1;
  vctrl_t     ctrl;
  csr_state_t csr_q;

  // last only steers busy inside the counter
  element_counter u_counter (
    .CLK, .nRST, .instr_valid, .stall, .flush, .vl(csr_q.vl),
    .accept, .busy, .offset, .last()
  );

  vctrl_decode u_ctrl (
    .CLK, .nRST, .accept, .instr, .xs1, .csr, .ctrl, .csr_q
  );

  operand_offset_gen u_offsets (
    .ctrl, .csr(csr_q), .offset, .rf_rsp, .rf_req,
    .vs2_offset0, .vs2_offset1, .woffset0, .woffset1
  );

  de_pipe_reg u_pipe (
    .CLK, .nRST, .stall, .flush, .busy, .ctrl, .csr(csr_q), .offset,
    .vs2_offset0, .vs2_offset1, .woffset0, .woffset1, .rf_rsp, .uop
  );

endmodule

// ==== dv/vdecode_props.sv ====
/*
  Concurrent checks bound into the decode stage top level.
  The instruction fields on rf_req must stay put for the whole walk.
*/
module vdecode_props (
  input logic                 CLK,
  input logic                 nRST,
  input logic                 busy,
  input logic                 flush,
  input vdecode_pkg::rf_req_t rf_req,
  input vdecode_pkg::de_uop_t uop
);
  timeunit 1ns;
  timeprecision 1ps;

  busy_after_reset: assert property (@(posedge CLK) $rose(nRST) |-> !busy)
    else $error("busy high in the cycle after reset release");

  // flush empties the micro-op register at the next edge
  valid_after_flush: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !uop.valid)
    else $error("uop.valid high after flush");

  wen_needs_valid: assert property (@(posedge CLK) disable iff (!nRST) |uop.wen |-> uop.valid)
    else $error("write enable set on an invalid micro-op");

  // a new instruction taken mid-walk would replace the held fields
  no_accept_busy: assert property (@(posedge CLK) disable iff (!nRST)
    busy |=> $stable({rf_req.vs1, rf_req.vs2, rf_req.vd, rf_req.sew}))
    else $error("instruction accepted while busy");

endmodule

bind vdecode_stage vdecode_props props (.CLK, .nRST, .busy, .flush, .rf_req, .uop);

// ==== dv/tb_vdecode.sv ====
/*
  Testbench for the vector decode stage with random OP-V instructions, random stall
  and occasional flush, checked against a micro-op model.
  The register file responder answers each lane from register, offset and lane.
*/
module tb_vdecode;
  timeunit 1ns;
  timeprecision 1ps;
  import vec_types_pkg::*;
  import vdecode_pkg::*;

  localparam int N_INSTR = 300;

  logic       CLK, nRST, instr_valid, stall, flush, busy;
  xword_t     instr, xs1;
  csr_state_t csr;
  rf_req_t    rf_req;
  rf_rsp_t    rf_rsp;
  de_uop_t    uop, prev_uop;
  de_uop_t    exp_q[$];
  valu_op_t   p_op, w_op;
  // instruction under walk, captured at acceptance
  logic [4:0] w_vs1, w_vs2, w_vd;
  logic [2:0] w_f3;
  logic       w_vm;
  xword_t     w_xs1;
  int         w_vl, w_sew, w_n;

  vdecode_stage dut (.*);

  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  function automatic xword_t rf_word(input logic [4:0] r, input logic [4:0] off, input int lane);
    return (32'h9e37_79b1 * {21'd0, r, off, lane[0]}) ^ {lane[0], r, off, 21'h0a5a5};
  endfunction

  // combinational register file
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      rf_rsp.vs1_data[i] = rf_word(rf_req.vs1, rf_req.vs1_offset, i);
      rf_rsp.vs2_data[i] = rf_word(rf_req.vs2, rf_req.vs2_offset, i);
      rf_rsp.vs3_data[i] = rf_word(rf_req.vd, rf_req.vd_offset, i);
      rf_rsp.v0_mask[i]  = rf_req.vs1_offset[0] ^ i[0];
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [63:0] e, input logic [63:0] g);
    if (e !== g) begin
      fail_run($sformatf("MISMATCH %s exp=%h got=%h", name, e, g));
    end
  endtask

  function automatic de_uop_t exp_uop(input int k);
    de_uop_t u;
    int      off, e;
    int      wo [2];
    int      vo [2];
    xword_t  v1 [2];
    xword_t  v2 [2];
    xword_t  v3 [2];
    xword_t  s;
    logic    mask;
    u   = '0;
    off = 2 * k;
    if (w_f3 == OPIVX || w_f3 == OPMVX) s = w_xs1;
    else if (w_op == VALU_ADD || w_op == VALU_SUB) s = {{27{w_vs1[4]}}, w_vs1};
    else s = {27'd0, w_vs1};
    for (int i = 0; i < 2; i++) begin
      wo[i] = (w_op == VALU_SLIDE1UP) ? off + i + 1 : off + i;
      v1[i] = rf_word(w_vs1, 5'(off), i);
      if (w_op == VALU_SLIDE1DOWN) vo[i] = off + i + 1;
      else if (w_op == VALU_RGATHER) vo[i] = int'(v1[i][4:0]);
      else vo[i] = off + i;
      v2[i] = rf_word(w_vs2, 5'(vo[0]), i);
      v3[i] = rf_word(w_vd, 5'(wo[0]), i);
      if (w_op == VALU_NSRL && w_sew == 2) v2[i] = {16'd0, v2[i][15:0]};
      else if (w_op == VALU_NSRL && w_sew == 1) v2[i] = {24'd0, v2[i][7:0]};
      else if (w_op == VALU_SLIDE1DOWN && off + i + 1 == w_vl) v2[i] = s;
      mask = ((off ^ i) & 1) == 1;
      u.wen[i] = (w_op != VALU_NOP) && (wo[i] < w_vl) && (w_vm || mask);
    end
    if (w_op == VALU_WADDU) e = (w_sew == 0) ? 1 : 2;
    else if (w_op == VALU_NSRL) e = (w_sew == 2) ? 1 : 0;
    else e = w_sew;
    u.valid = 1'b1;
    u.aluop = w_op;
    u.vd    = w_vd;
    u.eew   = sew_t'(e);
    u.sew   = sew_t'(w_sew);
    {u.woffset0, u.woffset1, u.vs2_offset0, u.vs2_offset1} =
      {5'(wo[0]), 5'(wo[1]), 5'(vo[0]), 5'(vo[1])};
    {u.vs1_lane0, u.vs1_lane1, u.vs2_lane0, u.vs2_lane1} = {v1[0], v1[1], v2[0], v2[1]};
    {u.vs3_lane0, u.vs3_lane1, u.scalar} = {v3[0], v3[1], s};
    return u;
  endfunction

  task automatic compare_uop(input de_uop_t e);
    check_val("uop.valid", e.valid, uop.valid);
    check_val("uop.aluop", e.aluop, uop.aluop);
    check_val("uop.vd", e.vd, uop.vd);
    check_val("uop.eew", e.eew, uop.eew);
    check_val("uop.sew", e.sew, uop.sew);
    check_val("uop.woffset0", e.woffset0, uop.woffset0);
    check_val("uop.woffset1", e.woffset1, uop.woffset1);
    check_val("uop.wen", e.wen, uop.wen);
    check_val("uop.vs1_lane0", e.vs1_lane0, uop.vs1_lane0);
    check_val("uop.vs1_lane1", e.vs1_lane1, uop.vs1_lane1);
    check_val("uop.vs2_lane0", e.vs2_lane0, uop.vs2_lane0);
    check_val("uop.vs2_lane1", e.vs2_lane1, uop.vs2_lane1);
    check_val("uop.vs3_lane0", e.vs3_lane0, uop.vs3_lane0);
    check_val("uop.vs3_lane1", e.vs3_lane1, uop.vs3_lane1);
    check_val("uop.scalar", e.scalar, uop.scalar);
    check_val("uop.vs2_offset0", e.vs2_offset0, uop.vs2_offset0);
    check_val("uop.vs2_offset1", e.vs2_offset1, uop.vs2_offset1);
  endtask

  task automatic new_instr();
    logic [12:0] kind;
    logic [2:0]  sew_f;
    // funct6, funct3 and the op they should decode to
    case ($urandom % 11)
      0:       kind = {F6_VADD, OPIVV, VALU_ADD};
      1:       kind = {F6_VADD, OPIVX, VALU_ADD};
      2:       kind = {F6_VADD, OPIVI, VALU_ADD};
      3:       kind = {F6_VSUB, OPIVV, VALU_SUB};
      4:       kind = {F6_VSUB, OPIVX, VALU_SUB};
      5:       kind = {F6_VSUB, OPIVI, VALU_NOP};
      6:       kind = {F6_VWADDU, OPMVV, VALU_WADDU};
      7:       kind = {F6_VNSRL, OPIVI, VALU_NSRL};
      8:       kind = {F6_VSLIDE1UP, OPMVX, VALU_SLIDE1UP};
      9:       kind = {F6_VSLIDE1DOWN, OPMVX, VALU_SLIDE1DOWN};
      default: kind = {F6_VRGATHER, OPIVV, VALU_RGATHER};
    endcase
    p_op      = valu_op_t'(kind[3:0]);
    sew_f     = 3'($urandom % 4);
    csr.vtype = {2'($urandom), sew_f, 3'($urandom)};
    csr.vl    = 5'($urandom % 17);
    xs1       = $urandom;
    instr     = {kind[12:7], 1'($urandom), 5'($urandom), 5'($urandom), kind[6:4],
                 5'($urandom), OPCODE_OPV};
    instr_valid = 1'b1;
  endtask

  // watchdog sized from the instruction count
  initial begin
    #(N_INSTR * 20 * 100);
    fail_run("timeout: the run did not finish in time");
  end

  initial begin
    int   accepted, flush_cnt;
    logic adv_q, acc_q, flush_q, stall_q;
    void'($urandom(32'h5d3c_3050));
    {nRST, instr_valid, stall, flush, instr, xs1, csr} = '0;
    {accepted, flush_cnt, adv_q, acc_q, flush_q, stall_q} = '0;
    repeat (2) @(posedge CLK);
    #5 nRST = 1'b1;
    check_val("busy", 0, busy);
    check_val("uop nonzero after reset", 0, |uop);
    new_instr();
    acc_q = instr_valid && !busy && !stall && !flush;
    while (accepted < N_INSTR || exp_q.size() != 0 || flush_q) begin
      @(posedge CLK);
      #5;
      if (flush_q) begin
        check_val("uop.valid", 0, uop.valid);
        exp_q.delete();
      end else if (adv_q) begin
        if (exp_q.size() == 0) fail_run("micro-op registered with no instruction in flight");
        compare_uop(exp_q.pop_front());
      end else if (stall_q) begin
        check_val("uop held under stall", 1, uop == prev_uop);
      end else begin
        check_val("uop.valid", 0, uop.valid);
      end
      if (acc_q) begin
        {w_vs1, w_vs2, w_vd, w_vm, w_f3} = {instr[19:15], instr[24:20], instr[11:7],
                                            instr[25], instr[14:12]};
        w_xs1 = xs1;
        w_op  = p_op;
        w_vl  = int'(csr.vl);
        w_sew = (csr.vtype[5:3] > 2) ? 2 : int'(csr.vtype[5:3]);
        w_n   = (w_vl == 0) ? 1 : (w_vl + 1) / 2;
        for (int k = 0; k < w_n; k++) exp_q.push_back(exp_uop(k));
        accepted++;
        if ($urandom % 100 < 3) flush_cnt = 1 + $urandom % w_n;
        if (accepted < N_INSTR) new_instr();
        else instr_valid = 1'b0;
      end
      check_val("busy", exp_q.size() != 0, busy);
      if (busy) begin
        check_val("rf_req.vs1_offset", 2 * (w_n - exp_q.size()), rf_req.vs1_offset);
        check_val("rf_req.sew", w_sew, rf_req.sew);
        check_val("rf_req.vs2_sew", (w_op == VALU_NSRL) ? ((w_sew == 0) ? 1 : 2) : w_sew,
                  rf_req.vs2_sew);
      end
      prev_uop = uop;
      stall    = ($urandom % 5) == 0;
      flush    = 1'b0;
      if (flush_cnt != 0 && busy) begin
        flush_cnt--;
        flush = (flush_cnt == 0);
      end
      adv_q   = busy && !stall && !flush;
      acc_q   = instr_valid && !busy && !stall && !flush;
      flush_q = flush;
      stall_q = stall;
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/vec_types_pkg.sv
rtl/vdecode_pkg.sv
rtl/vctrl_decode.sv
rtl/element_counter.sv
rtl/operand_offset_gen.sv
rtl/de_pipe_reg.sv
rtl/vdecode_stage.sv
dv/vdecode_props.sv
dv/tb_vdecode.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_vdecode -o sim_vdecode &&
  ./obj_dir/sim_vdecode | tee /dev/stderr | grep -q "STATUS: PASS" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }
